/* verilog/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// accumulator and data memory byte width
`define DATA_W 8
// program and data memory address width, also the info field width
`define ADDR_W 10
// opcode field in the upper instruction bits
`define OPC_W 6
`define INSTR_W 16
// signed relative branch offset
`define OFFS_W 6
// memory depths follow the 10-bit address field
`define PROG_DEPTH 1024
`define DATA_DEPTH 1024

`endif

/* verilog/cpuPkg.sv */
`default_nettype none
`include "cpu_config.svh"

package cpuPkg;

	// instruction opcodes, upper bits of the instruction word
	typedef enum logic [`OPC_W-1:0] {
		NOP   = 6'd0,
		// memory and constant loads
		LDA   = 6'd1,  LDB   = 6'd2,  LDCA  = 6'd3,  LDCB  = 6'd4,
		// stores to absolute address
		STA   = 6'd5,  STB   = 6'd6,
		// register forms, both accumulators
		ADDA  = 6'd7,  ADDB  = 6'd8,  SUBA  = 6'd9,  SUBB  = 6'd10,
		ANDA  = 6'd11, ANDB  = 6'd12, ORA   = 6'd13, ORB   = 6'd14,
		// constant forms
		ADDCA = 6'd15, ADDCB = 6'd16, SUBCA = 6'd17, SUBCB = 6'd18,
		ANDCA = 6'd19, ANDCB = 6'd20, ORCA  = 6'd21, ORCB  = 6'd22,
		// shifts through carry, A only
		ASLA  = 6'd23, ASRA  = 6'd24,
		// absolute jump
		JMP   = 6'd25,
		// relative branches tested on A
		BAEQ  = 6'd26, BANE  = 6'd27, BACS  = 6'd28,
		BACC  = 6'd29, BAMI  = 6'd30, BAPL  = 6'd31,
		// relative branches tested on B
		BBEQ  = 6'd32, BBNE  = 6'd33, BBCS  = 6'd34,
		BBCC  = 6'd35, BBMI  = 6'd36, BBPL  = 6'd37
	} opcodeT;

	// what the execute stage writes into the accumulators
	typedef enum logic [2:0] {
		noLoad        = 3'd0,
		loadConstantA = 3'd1,
		loadResultA   = 3'd2,
		loadConstantB = 3'd3,
		loadResultB   = 3'd4
	} acumCtrlT;

	// bit 0 picks acum A over constant for operand 1
	// bit 1 picks acum B over constant for operand 2
	typedef enum logic [1:0] {
		selConstants   = 2'b00,
		selAcumAConstB = 2'b01,
		selConstAAcumB = 2'b10,
		selAcumAB      = 2'b11
	} operandSelT;

endpackage

`default_nettype wire

/* verilog/idExIf.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

interface idExIf;

	// cleared by a taken branch or reset
	logic valid;
	// full opcode, store source select in execute
	cpuPkg::opcodeT opcode;
	// NOP for everything the alu does not touch
	cpuPkg::opcodeT aluOp;
	cpuPkg::operandSelT outSelMux;
	cpuPkg::acumCtrlT controlAcum;
	// store strobe
	logic memEnable;
	// result comes from data memory
	logic memLoad;
	logic [`DATA_W-1:0] constant;
	// forwarded accumulator values
	logic [`DATA_W-1:0] acumA;
	logic [`DATA_W-1:0] acumB;
	// branch target or data address
	logic [`ADDR_W-1:0] branchDir;
	logic isBranch;

	modport decode (
		output valid, opcode, aluOp, outSelMux, controlAcum, memEnable,
		output memLoad, constant, acumA, acumB, branchDir, isBranch
	);

	modport execute (
		input valid, opcode, aluOp, outSelMux, controlAcum, memEnable,
		input memLoad, constant, acumA, acumB, branchDir, isBranch
	);

endinterface

`default_nettype wire

/* verilog/fetch.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module fetch (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 run,
	input  wire                 progWe,
	input  wire [`ADDR_W-1:0]   progAddr,
	input  wire [`INSTR_W-1:0]  progData,
	input  wire                 branchTaken,
	input  wire [`ADDR_W-1:0]   branchDir,
	output logic [`ADDR_W-1:0]  pc,
	output logic [`INSTR_W-1:0] instr,
	output logic [`ADDR_W-1:0]  instrPc
);

	// bubble word, NOP opcode with an empty info field
	localparam logic [`INSTR_W-1:0] nopWord = {cpuPkg::NOP, {`ADDR_W{1'b0}}};

	logic [`INSTR_W-1:0] progMem [`PROG_DEPTH];

	// loaded by the host only while the core is stopped
	always_ff @(posedge clk) begin
		if (progWe && !run) begin
			progMem[progAddr] <= progData;
		end
	end

	// pc and instruction register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			instr <= nopWord;
		end else if (!run) begin
			// stopped, pc holds
			instr <= nopWord;
		end else if (branchTaken) begin
			// redirect and squash the word read this cycle
			pc <= branchDir;
			instr <= nopWord;
		end else begin
			pc <= pc + 1'b1;
			instr <= progMem[pc];
		end
	end

	// address of the issued word, base for relative branches
	always_ff @(posedge clk) begin
		if (run) begin
			instrPc <= pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module decoder (
	input  wire                clk,
	input  wire                rstN,
	input  wire [`INSTR_W-1:0] instr,
	input  wire [`ADDR_W-1:0]  instrPc,
	input  wire                branchTaken,
	input  wire [`DATA_W-1:0]  acumA,
	input  wire [`DATA_W-1:0]  acumB,
	idExIf.decode              idEx
);

	cpuPkg::opcodeT decOp;
	cpuPkg::opcodeT decAluOp;
	cpuPkg::operandSelT decSel;
	cpuPkg::acumCtrlT decCtrl;
	logic decMemEnable;
	logic decMemLoad;
	logic decIsBranch;
	logic [`ADDR_W-1:0] info;
	logic [`OFFS_W-1:0] offset;
	logic [`ADDR_W-1:0] decBranchDir;

	// opcode on top, info field below
	assign decOp = cpuPkg::opcodeT'(instr[`INSTR_W-1 -: `OPC_W]);
	assign info = instr[`ADDR_W-1:0];
	assign offset = info[`OFFS_W-1:0];

	always_comb begin
		decAluOp = cpuPkg::NOP;
		decSel = cpuPkg::selConstants;
		decCtrl = cpuPkg::noLoad;
		decMemEnable = 1'b0;
		decMemLoad = 1'b0;
		decIsBranch = 1'b0;
		case (decOp)
			cpuPkg::LDA: begin
				decCtrl = cpuPkg::loadResultA;
				decMemLoad = 1'b1;
			end
			cpuPkg::LDB: begin
				decCtrl = cpuPkg::loadResultB;
				decMemLoad = 1'b1;
			end
			cpuPkg::LDCA: decCtrl = cpuPkg::loadConstantA;
			cpuPkg::LDCB: decCtrl = cpuPkg::loadConstantB;
			// store source picked in execute from the opcode
			cpuPkg::STA, cpuPkg::STB: begin
				decSel = cpuPkg::selAcumAB;
				decMemEnable = 1'b1;
			end
			// A <- A op B, shifts work on A
			cpuPkg::ADDA, cpuPkg::SUBA, cpuPkg::ANDA, cpuPkg::ORA,
			cpuPkg::ASLA, cpuPkg::ASRA: begin
				decAluOp = decOp;
				decSel = cpuPkg::selAcumAB;
				decCtrl = cpuPkg::loadResultA;
			end
			// B <- A op B
			cpuPkg::ADDB, cpuPkg::SUBB, cpuPkg::ANDB, cpuPkg::ORB: begin
				decAluOp = decOp;
				decSel = cpuPkg::selAcumAB;
				decCtrl = cpuPkg::loadResultB;
			end
			// A <- A op const
			cpuPkg::ADDCA, cpuPkg::SUBCA, cpuPkg::ANDCA, cpuPkg::ORCA: begin
				decAluOp = decOp;
				decSel = cpuPkg::selAcumAConstB;
				decCtrl = cpuPkg::loadResultA;
			end
			// B <- B op const, const rides on operand 1
			cpuPkg::ADDCB, cpuPkg::SUBCB, cpuPkg::ANDCB, cpuPkg::ORCB: begin
				decAluOp = decOp;
				decSel = cpuPkg::selConstAAcumB;
				decCtrl = cpuPkg::loadResultB;
			end
			cpuPkg::JMP: begin
				decAluOp = decOp;
				decIsBranch = 1'b1;
			end
			// conditions need both accumulators on the operands
			cpuPkg::BAEQ, cpuPkg::BANE, cpuPkg::BACS, cpuPkg::BACC,
			cpuPkg::BAMI, cpuPkg::BAPL, cpuPkg::BBEQ, cpuPkg::BBNE,
			cpuPkg::BBCS, cpuPkg::BBCC, cpuPkg::BBMI, cpuPkg::BBPL: begin
				decAluOp = decOp;
				decSel = cpuPkg::selAcumAB;
				decIsBranch = 1'b1;
			end
			default: ;
		endcase
	end

	// absolute field for jump and memory ops, else pc relative
	always_comb begin
		case (decOp)
			cpuPkg::JMP, cpuPkg::STA, cpuPkg::STB, cpuPkg::LDA, cpuPkg::LDB:
				decBranchDir = info;
			default:
				decBranchDir = instrPc + 1'b1 +
					{{(`ADDR_W-`OFFS_W){offset[`OFFS_W-1]}}, offset};
		endcase
	end

	// squash the word behind a taken branch
	always_ff @(posedge clk) begin
		if (!rstN) begin
			idEx.valid <= 1'b0;
		end else begin
			idEx.valid <= !branchTaken;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		idEx.opcode <= decOp;
		idEx.aluOp <= decAluOp;
		idEx.outSelMux <= decSel;
		idEx.controlAcum <= decCtrl;
		idEx.memEnable <= decMemEnable;
		idEx.memLoad <= decMemLoad;
		idEx.constant <= info[`DATA_W-1:0];
		idEx.acumA <= acumA;
		idEx.acumB <= acumB;
		idEx.branchDir <= decBranchDir;
		idEx.isBranch <= decIsBranch;
	end

endmodule

`default_nettype wire

/* verilog/accumAB.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module accumAB (
	input  wire                clk,
	input  wire                rstN,
	input  wire                wrA,
	input  wire                wrB,
	input  wire [`DATA_W-1:0]  wrData,
	input  wire                carryWe,
	input  wire                carryIn,
	output logic [`DATA_W-1:0] acumA,
	output logic [`DATA_W-1:0] acumB,
	output logic               carry
);

	logic [`DATA_W-1:0] acumAReg;
	logic [`DATA_W-1:0] acumBReg;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acumAReg <= '0;
			acumBReg <= '0;
			carry <= 1'b0;
		end else begin
			if (wrA) begin
				acumAReg <= wrData;
			end
			if (wrB) begin
				acumBReg <= wrData;
			end
			if (carryWe) begin
				carry <= carryIn;
			end
		end
	end

	// write-through so decode sees the result of execute
	assign acumA = wrA ? wrData : acumAReg;
	assign acumB = wrB ? wrData : acumBReg;

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module alu (
	input  wire [`DATA_W-1:0]  iAluOper1,
	input  wire [`DATA_W-1:0]  iAluOper2,
	input  cpuPkg::opcodeT     iAluInstSel,
	input  wire                carryIn,
	output logic [`DATA_W-1:0] oAluData,
	output logic               carryOut,
	output logic               carryWe,
	output logic               branchTaken
);

	// one extra bit catches carry or borrow
	logic [`DATA_W:0] sum;
	logic [`DATA_W:0] diff;
	logic [`DATA_W:0] diffRev;

	assign sum = {1'b0, iAluOper1} + {1'b0, iAluOper2};
	assign diff = {1'b0, iAluOper1} - {1'b0, iAluOper2};
	// B - const, const sits on operand 1
	assign diffRev = {1'b0, iAluOper2} - {1'b0, iAluOper1};

	always_comb begin
		oAluData = '0;
		carryOut = carryIn;
		carryWe = 1'b0;
		branchTaken = 1'b0;
		case (iAluInstSel)
			cpuPkg::ADDA, cpuPkg::ADDB, cpuPkg::ADDCA, cpuPkg::ADDCB: begin
				{carryOut, oAluData} = sum;
				carryWe = 1'b1;
			end
			cpuPkg::SUBA, cpuPkg::SUBB, cpuPkg::SUBCA: begin
				{carryOut, oAluData} = diff;
				carryWe = 1'b1;
			end
			cpuPkg::SUBCB: begin
				{carryOut, oAluData} = diffRev;
				carryWe = 1'b1;
			end
			// logic ops keep the flag
			cpuPkg::ANDA, cpuPkg::ANDB, cpuPkg::ANDCA, cpuPkg::ANDCB:
				oAluData = iAluOper1 & iAluOper2;
			cpuPkg::ORA, cpuPkg::ORB, cpuPkg::ORCA, cpuPkg::ORCB:
				oAluData = iAluOper1 | iAluOper2;
			// C <- A <- 0
			cpuPkg::ASLA: begin
				{carryOut, oAluData} = {iAluOper1, 1'b0};
				carryWe = 1'b1;
			end
			// C -> A -> C
			cpuPkg::ASRA: begin
				{oAluData, carryOut} = {carryIn, iAluOper1};
				carryWe = 1'b1;
			end
			cpuPkg::JMP: branchTaken = 1'b1;
			// A conditions on operand 1
			cpuPkg::BAEQ: branchTaken = (iAluOper1 == '0);
			cpuPkg::BANE: branchTaken = (iAluOper1 != '0);
			cpuPkg::BACS: branchTaken = carryIn;
			cpuPkg::BACC: branchTaken = !carryIn;
			cpuPkg::BAMI: branchTaken = iAluOper1[`DATA_W-1];
			cpuPkg::BAPL: branchTaken = !iAluOper1[`DATA_W-1];
			// B conditions on operand 2
			cpuPkg::BBEQ: branchTaken = (iAluOper2 == '0);
			cpuPkg::BBNE: branchTaken = (iAluOper2 != '0);
			cpuPkg::BBCS: branchTaken = carryIn;
			cpuPkg::BBCC: branchTaken = !carryIn;
			cpuPkg::BBMI: branchTaken = iAluOper2[`DATA_W-1];
			cpuPkg::BBPL: branchTaken = !iAluOper2[`DATA_W-1];
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ex.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module ex (
	idExIf.execute             idEx,
	input  wire                carry,
	input  wire [`DATA_W-1:0]  memRData,
	output logic               branchTaken,
	output logic [`ADDR_W-1:0] branchDir,
	output logic               wrA,
	output logic               wrB,
	output logic [`DATA_W-1:0] wrData,
	output logic               carryWe,
	output logic               carryIn,
	output logic               memWe,
	output logic [`ADDR_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWData
);

	logic [`DATA_W-1:0] aluOper1;
	logic [`DATA_W-1:0] aluOper2;
	logic [`DATA_W-1:0] aluData;
	logic aluCarryWe;
	logic aluBranch;
	logic loadConst;

	// accumulator or constant per operand
	assign aluOper1 = idEx.outSelMux[0] ? idEx.acumA : idEx.constant;
	assign aluOper2 = idEx.outSelMux[1] ? idEx.acumB : idEx.constant;

	alu aluEx (
		.iAluOper1(aluOper1),
		.iAluOper2(aluOper2),
		.iAluInstSel(idEx.aluOp),
		.carryIn(carry),
		.oAluData(aluData),
		.carryOut(carryIn),
		.carryWe(aluCarryWe),
		.branchTaken(aluBranch)
	);

	assign loadConst = (idEx.controlAcum == cpuPkg::loadConstantA) ||
		(idEx.controlAcum == cpuPkg::loadConstantB);
	assign wrA = idEx.valid && ((idEx.controlAcum == cpuPkg::loadConstantA) ||
		(idEx.controlAcum == cpuPkg::loadResultA));
	assign wrB = idEx.valid && ((idEx.controlAcum == cpuPkg::loadConstantB) ||
		(idEx.controlAcum == cpuPkg::loadResultB));
	// constant, memory byte or alu result
	assign wrData = loadConst ? idEx.constant : (idEx.memLoad ? memRData : aluData);
	assign carryWe = idEx.valid && aluCarryWe;

	// same field serves as data address
	assign memAddr = idEx.branchDir;
	assign memWe = idEx.valid && idEx.memEnable;
	assign memWData = (idEx.opcode == cpuPkg::STA) ? idEx.acumA : idEx.acumB;

	assign branchTaken = idEx.valid && idEx.isBranch && aluBranch;
	assign branchDir = idEx.branchDir;

endmodule

`default_nettype wire

/* verilog/dataMem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module dataMem (
	input  wire                clk,
	input  wire                memWe,
	input  wire [`ADDR_W-1:0]  memAddr,
	input  wire [`DATA_W-1:0]  memWData,
	output logic [`DATA_W-1:0] memRData
);

	logic [`DATA_W-1:0] mem [`DATA_DEPTH];

	// store lands on the edge closing the execute cycle
	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[memAddr] <= memWData;
		end
	end

	// loads read within execute
	assign memRData = mem[memAddr];

endmodule

`default_nettype wire

/* verilog/accumCpu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module accumCpu (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 run,
	input  wire                 progWe,
	input  wire [`ADDR_W-1:0]   progAddr,
	input  wire [`INSTR_W-1:0]  progData,
	output logic [`ADDR_W-1:0]  pc,
	output logic [`DATA_W-1:0]  acumA,
	output logic [`DATA_W-1:0]  acumB,
	output logic                carry,
	output logic                memWe,
	output logic [`ADDR_W-1:0]  memAddr,
	output logic [`DATA_W-1:0]  memWData
);

	logic [`INSTR_W-1:0] instr;
	logic [`ADDR_W-1:0] instrPc;
	logic branchTaken;
	logic [`ADDR_W-1:0] branchDir;
	logic wrA;
	logic wrB;
	logic [`DATA_W-1:0] wrData;
	logic carryWe;
	logic carryIn;
	logic [`DATA_W-1:0] memRData;

	// decode to execute stage register
	idExIf idEx ();

	fetch fetchI (
		.clk(clk), .rstN(rstN), .run(run),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.branchTaken(branchTaken), .branchDir(branchDir),
		.pc(pc), .instr(instr), .instrPc(instrPc)
	);

	decoder decoderI (
		.clk(clk), .rstN(rstN), .instr(instr), .instrPc(instrPc),
		.branchTaken(branchTaken), .acumA(acumA), .acumB(acumB),
		.idEx(idEx.decode)
	);

	// forwarded values also feed the top-level outputs
	accumAB accumABI (
		.clk(clk), .rstN(rstN), .wrA(wrA), .wrB(wrB), .wrData(wrData),
		.carryWe(carryWe), .carryIn(carryIn),
		.acumA(acumA), .acumB(acumB), .carry(carry)
	);

	ex exI (
		.idEx(idEx.execute), .carry(carry), .memRData(memRData),
		.branchTaken(branchTaken), .branchDir(branchDir),
		.wrA(wrA), .wrB(wrB), .wrData(wrData),
		.carryWe(carryWe), .carryIn(carryIn),
		.memWe(memWe), .memAddr(memAddr), .memWData(memWData)
	);

	dataMem dataMemI (
		.clk(clk), .memWe(memWe), .memAddr(memAddr),
		.memWData(memWData), .memRData(memRData)
	);

endmodule

`default_nettype wire

/* tb/accumCpu_properties.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module accumCpuProperties (
	input wire               clk,
	input wire               rstN,
	input wire               run,
	input wire               memWe,
	input wire [`ADDR_W-1:0] pc
);

	// ID/EX valid is cleared by reset, so no store follows a reset edge
	memWeInReset: assert property (@(posedge clk) !rstN |=> !memWe)
		else $error("memWe high right after a reset edge");

	// pc register always has a known value once out of reset
	pcKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(pc))
		else $error("pc has unknown bits");

	// stopped core keeps its pc
	pcHolds: assert property (@(posedge clk) disable iff (!rstN) !run |=> $stable(pc))
		else $error("pc moved while run was low");

endmodule

bind accumCpu accumCpuProperties accumCpuPropsI (
	.clk(clk), .rstN(rstN), .run(run), .memWe(memWe), .pc(pc)
);

`default_nettype wire

/* tb/accumCpuTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module accumCpuTb;

	localparam int numTests = 6;
	// 400 cycles per test covers load and run of the longest program
	localparam int cycleLimit = 400 * numTests;

	logic clk;
	logic rstN;
	logic run;
	logic progWe;
	logic [`ADDR_W-1:0] progAddr;
	logic [`INSTR_W-1:0] progData;
	logic [`ADDR_W-1:0] pc;
	logic [`DATA_W-1:0] acumA;
	logic [`DATA_W-1:0] acumB;
	logic carry;
	logic memWe;
	logic [`ADDR_W-1:0] memAddr;
	logic [`DATA_W-1:0] memWData;

	// program under test indexed by word address
	logic [`INSTR_W-1:0] prog[$];
	// address and data pairs seen on the bus and predicted by the model
	logic [`ADDR_W+`DATA_W-1:0] seenStores[$];
	logic [`ADDR_W+`DATA_W-1:0] expStores[$];
	// reference machine state
	logic [`DATA_W-1:0] mA;
	logic [`DATA_W-1:0] mB;
	logic mC;
	logic [`DATA_W-1:0] modelMem [`DATA_DEPTH];
	logic [31:0] lfsr;
	int checks;
	int failures;
	int cycles;

	accumCpu accumCpu_i (
		.clk(clk), .rstN(rstN), .run(run),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.pc(pc), .acumA(acumA), .acumB(acumB), .carry(carry),
		.memWe(memWe), .memAddr(memAddr), .memWData(memWData)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// hung run guard
	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", cycleLimit);
		$display("Checks failed");
		$finish;
	end

	// every store cycle leaves one address and data pair
	always @(negedge clk) begin
		if (memWe === 1'b1) begin
			seenStores.push_back({memAddr, memWData});
		end
	end

	// random bits in the low end of an info field
	function automatic logic [`ADDR_W-1:0] randBits(input int n);
		logic [`ADDR_W-1:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			// galois step with taps x^32+x^22+x^2+x+1
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r[i] = lfsr[0];
		end
		return r;
	endfunction

	function automatic logic [`ADDR_W-1:0] toAddr(input int v);
		return v[`ADDR_W-1:0];
	endfunction

	task automatic emit(input cpuPkg::opcodeT op, input logic [`ADDR_W-1:0] info);
		prog.push_back({op, info});
	endtask

	// offset counts from the word after the branch
	task automatic emitBranch(input cpuPkg::opcodeT op, input int target);
		int off;
		off = target - prog.size() - 1;
		emit(op, {{(`ADDR_W-`OFFS_W){1'b0}}, off[`OFFS_W-1:0]});
	endtask

	// programs end in a jump to itself
	task automatic emitHalt();
		emit(cpuPkg::JMP, toAddr(prog.size()));
	endtask

	// carry is the ninth bit of the sum
	function automatic logic [7:0] addC(input logic [7:0] x, input logic [7:0] y);
		mC = (int'(x) + int'(y)) > 255;
		return x + y;
	endfunction

	// carry is the borrow
	function automatic logic [7:0] subC(input logic [7:0] x, input logic [7:0] y);
		mC = x < y;
		return x - y;
	endfunction

	function automatic logic branchCond(input cpuPkg::opcodeT op);
		case (op)
			cpuPkg::BAEQ: return mA == 8'h00;
			cpuPkg::BANE: return mA != 8'h00;
			cpuPkg::BAMI: return mA[7];
			cpuPkg::BAPL: return !mA[7];
			cpuPkg::BBEQ: return mB == 8'h00;
			cpuPkg::BBNE: return mB != 8'h00;
			cpuPkg::BBMI: return mB[7];
			cpuPkg::BBPL: return !mB[7];
			cpuPkg::BACS, cpuPkg::BBCS: return mC;
			cpuPkg::BACC, cpuPkg::BBCC: return !mC;
			default: return 1'b0;
		endcase
	endfunction

	task automatic storeModel(input logic [`ADDR_W-1:0] a, input logic [7:0] d);
		modelMem[a] = d;
		expStores.push_back({a, d});
	endtask

	// instruction level model, one word per step
	task automatic modelRun(input int haltAddr);
		int p;
		int nxt;
		int steps;
		int rel;
		logic [`INSTR_W-1:0] w;
		logic [`ADDR_W-1:0] field;
		logic [7:0] k;
		logic bitOut;
		cpuPkg::opcodeT op;
		p = 0;
		steps = 0;
		mA = '0;
		mB = '0;
		mC = 1'b0;
		expStores.delete();
		while (p != haltAddr && steps < 2000) begin
			w = prog[p];
			op = cpuPkg::opcodeT'(w[`INSTR_W-1 -: `OPC_W]);
			field = w[`ADDR_W-1:0];
			k = field[7:0];
			rel = p + 1 + $signed(field[`OFFS_W-1:0]);
			nxt = p + 1;
			steps++;
			case (op)
				cpuPkg::LDA: mA = modelMem[field];
				cpuPkg::LDB: mB = modelMem[field];
				cpuPkg::LDCA: mA = k;
				cpuPkg::LDCB: mB = k;
				cpuPkg::STA: storeModel(field, mA);
				cpuPkg::STB: storeModel(field, mB);
				// register forms take A and B
				cpuPkg::ADDA: mA = addC(mA, mB);
				cpuPkg::ADDB: mB = addC(mA, mB);
				cpuPkg::SUBA: mA = subC(mA, mB);
				cpuPkg::SUBB: mB = subC(mA, mB);
				cpuPkg::ANDA: mA = mA & mB;
				cpuPkg::ANDB: mB = mA & mB;
				cpuPkg::ORA: mA = mA | mB;
				cpuPkg::ORB: mB = mA | mB;
				cpuPkg::ADDCA: mA = addC(mA, k);
				cpuPkg::ADDCB: mB = addC(mB, k);
				cpuPkg::SUBCA: mA = subC(mA, k);
				cpuPkg::SUBCB: mB = subC(mB, k);
				cpuPkg::ANDCA: mA = mA & k;
				cpuPkg::ANDCB: mB = mB & k;
				cpuPkg::ORCA: mA = mA | k;
				cpuPkg::ORCB: mB = mB | k;
				cpuPkg::ASLA: begin
					bitOut = mA[7];
					mA = mA << 1;
					mC = bitOut;
				end
				cpuPkg::ASRA: begin
					bitOut = mA[0];
					mA = {mC, mA[7:1]};
					mC = bitOut;
				end
				cpuPkg::JMP: nxt = field;
				default: begin
					if (branchCond(op)) begin
						nxt = rel;
					end
				end
			endcase
			p = nxt;
		end
	endtask

	task automatic checkVal(input string name, input logic [15:0] got,
		input logic [15:0] want);
		checks++;
		assert (got === want) else begin
			$display("error %s got %h expected %h", name, got, want);
			failures++;
		end
	endtask

	task automatic checkStores();
		int i;
		checks++;
		assert (seenStores.size() == expStores.size()) else begin
			$display("wrong number of stores, saw %0d but expected %0d",
				seenStores.size(), expStores.size());
			failures++;
		end
		if (seenStores.size() == expStores.size()) begin
			for (i = 0; i < expStores.size(); i++) begin
				checkVal("memAddr", 16'(seenStores[i][`ADDR_W+`DATA_W-1:`DATA_W]),
					16'(expStores[i][`ADDR_W+`DATA_W-1:`DATA_W]));
				checkVal("memWData", 16'(seenStores[i][`DATA_W-1:0]),
					16'(expStores[i][`DATA_W-1:0]));
			end
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;
	endtask

	// host writes while the core is stopped
	task automatic loadProgram();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			progWe = 1'b1;
			progAddr = toAddr(i);
			progData = prog[i];
			@(negedge clk);
		end
		progWe = 1'b0;
	endtask

	// run until pc shows the self-jump and let the pipeline drain
	task automatic runProgram();
		int haltAddr;
		haltAddr = prog.size() - 1;
		applyReset();
		loadProgram();
		modelRun(haltAddr);
		seenStores.delete();
		run = 1'b1;
		do begin
			@(negedge clk);
		end while (pc !== toAddr(haltAddr));
		repeat (4) @(negedge clk);
		checkVal("acumA", 16'(acumA), 16'(mA));
		checkVal("acumB", 16'(acumB), 16'(mB));
		checkVal("carry", 16'(carry), 16'(mC));
		checkStores();
		run = 1'b0;
	endtask

	task automatic endTest(input string name, input int f0);
		$display("test %s finished, %0d failures", name, failures - f0);
	endtask

	task automatic testArith();
		cpuPkg::opcodeT ops [16];
		int f0;
		int r;
		int i;
		f0 = failures;
		// even slots write A and odd slots write B
		// last carry writer is a subtract so the borrow shows at the end
		ops = '{cpuPkg::ADDA, cpuPkg::ADDCB, cpuPkg::SUBA, cpuPkg::SUBCB,
			cpuPkg::ANDCA, cpuPkg::ORB, cpuPkg::SUBCA, cpuPkg::ADDB,
			cpuPkg::ORCA, cpuPkg::ANDB, cpuPkg::ADDCA, cpuPkg::SUBB,
			cpuPkg::ORA, cpuPkg::ANDCB, cpuPkg::ANDA, cpuPkg::ORCB};
		prog.delete();
		for (r = 0; r < 2; r++) begin
			emit(cpuPkg::LDCA, randBits(8));
			emit(cpuPkg::LDCB, randBits(8));
			for (i = 0; i < 16; i++) begin
				emit(ops[i], randBits(8));
				// intermediate results leave through stores
				emit(i[0] ? cpuPkg::STB : cpuPkg::STA, toAddr('h200 + prog.size()));
			end
		end
		emitHalt();
		runProgram();
		endTest("arith", f0);
	endtask

	task automatic testShifts();
		int f0;
		int i;
		f0 = failures;
		prog.delete();
		// carry starts set so ASRA shifts a one in
		emit(cpuPkg::LDCA, 10'h0ff);
		emit(cpuPkg::ADDCA, 10'h001);
		emit(cpuPkg::LDCA, randBits(8));
		for (i = 0; i < 14; i++) begin
			emit(randBits(1) != 0 ? cpuPkg::ASLA : cpuPkg::ASRA, '0);
			emit(cpuPkg::STA, toAddr('h300 + i));
		end
		emitHalt();
		runProgram();
		endTest("shifts", f0);
	endtask

	task automatic testMemory();
		int f0;
		f0 = failures;
		prog.delete();
		emit(cpuPkg::LDCA, randBits(8));
		emit(cpuPkg::LDCB, randBits(8));
		emit(cpuPkg::STA, 10'h155);
		emit(cpuPkg::STB, 10'h2aa);
		// load right behind the store to the same byte
		emit(cpuPkg::STA, 10'h100);
		emit(cpuPkg::LDB, 10'h100);
		emit(cpuPkg::LDCA, 10'h000);
		emit(cpuPkg::LDA, 10'h2aa);
		emit(cpuPkg::STB, 10'h3ff);
		emit(cpuPkg::LDB, 10'h155);
		emitHalt();
		runProgram();
		endTest("memory", f0);
	endtask

	// each word depends on the one right before it
	task automatic testForwarding();
		int f0;
		f0 = failures;
		prog.delete();
		emit(cpuPkg::LDCB, randBits(8));
		emit(cpuPkg::LDCA, randBits(8));
		emit(cpuPkg::ADDCA, randBits(8));
		emit(cpuPkg::ADDA, '0);
		emit(cpuPkg::SUBB, '0);
		emit(cpuPkg::ORA, '0);
		emit(cpuPkg::STA, 10'h040);
		emit(cpuPkg::ASLA, '0);
		emit(cpuPkg::ADDB, '0);
		emit(cpuPkg::STB, 10'h041);
		emitHalt();
		runProgram();
		endTest("forwarding", f0);
	endtask

	task automatic testBranches();
		cpuPkg::opcodeT ops [12];
		int f0;
		int i;
		int s;
		int loopTop;
		f0 = failures;
		ops = '{cpuPkg::BAEQ, cpuPkg::BANE, cpuPkg::BACS, cpuPkg::BACC,
			cpuPkg::BAMI, cpuPkg::BAPL, cpuPkg::BBEQ, cpuPkg::BBNE,
			cpuPkg::BBCS, cpuPkg::BBCC, cpuPkg::BBMI, cpuPkg::BBPL};
		prog.delete();
		for (i = 0; i < 12; i++) begin
			// two setups flip every condition
			for (s = 0; s < 2; s++) begin
				// carry first since loads leave it alone
				emit(cpuPkg::LDCA, s != 0 ? 10'h000 : 10'h0ff);
				emit(cpuPkg::ADDCA, s != 0 ? 10'h000 : 10'h001);
				emit(cpuPkg::LDCA, s != 0 ? 10'h085 : 10'h000);
				emit(cpuPkg::LDCB, s != 0 ? 10'h000 : 10'h080);
				emitBranch(ops[i], prog.size() + 3);
				// shadow stores show up on the bus if not squashed
				emit(cpuPkg::STA, 10'h3e0);
				emit(cpuPkg::STB, 10'h3e2);
			end
		end
		// backward loops
		emit(cpuPkg::LDCA, 10'h003);
		loopTop = prog.size();
		emit(cpuPkg::SUBCA, 10'h001);
		emitBranch(cpuPkg::BANE, loopTop);
		emit(cpuPkg::LDCB, 10'h0fd);
		loopTop = prog.size();
		emit(cpuPkg::ADDCB, 10'h001);
		emitBranch(cpuPkg::BBNE, loopTop);
		emit(cpuPkg::LDCA, 10'h0fc);
		loopTop = prog.size();
		emit(cpuPkg::ADDCA, 10'h001);
		emitBranch(cpuPkg::BACC, loopTop);
		// absolute jump over two words
		emit(cpuPkg::JMP, toAddr(prog.size() + 3));
		emit(cpuPkg::STB, 10'h3e1);
		emit(cpuPkg::LDCA, 10'h055);
		emit(cpuPkg::NOP, '0);
		emit(cpuPkg::NOP, '0);
		emitHalt();
		runProgram();
		endTest("branches", f0);
	endtask

	// reset lands while a store sits in decode
	task automatic testMidReset();
		int f0;
		f0 = failures;
		prog.delete();
		emit(cpuPkg::LDCA, randBits(8) | 10'h001);
		emit(cpuPkg::LDCB, randBits(8) | 10'h001);
		emit(cpuPkg::ADDA, '0);
		emit(cpuPkg::STA, 10'h077);
		emit(cpuPkg::STB, 10'h078);
		emitHalt();
		applyReset();
		loadProgram();
		seenStores.delete();
		run = 1'b1;
		do begin
			@(negedge clk);
		end while (pc !== toAddr(4));
		rstN = 1'b0;
		run = 1'b0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		checkVal("pc", 16'(pc), 16'h0000);
		checkVal("acumA", 16'(acumA), 16'h0000);
		checkVal("acumB", 16'(acumB), 16'h0000);
		checkVal("carry", 16'(carry), 16'h0000);
		checks++;
		assert (seenStores.size() == 0) else begin
			$display("a store was issued although reset came first");
			failures++;
		end
		endTest("midReset", f0);
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		lfsr = 32'h70dd5b52;
		checks = 0;
		failures = 0;
		testArith();
		testShifts();
		testMemory();
		testForwarding();
		testBranches();
		testMidReset();
		$display("checks %0d, failures %0d", checks, failures);
		if (failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/idExIf.sv
verilog/fetch.sv
verilog/decoder.sv
verilog/accumAB.sv
verilog/alu.sv
verilog/ex.sv
verilog/dataMem.sv
verilog/accumCpu.sv
tb/accumCpu_properties.sv
tb/accumCpuTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module accumCpuTb \
	-o accumCpuSim &&
./obj_dir/accumCpuSim > sim.log 2>&1 || echo "build or simulation error" >> sim.log
cat sim.log
grep -qx "All checks passed" sim.log && echo PASS || { echo FAIL; exit 1; }
